// File: branch_predictor_top.f
+incdir+rtl
rtl/bpred_pkg.sv
rtl/predictor_table.sv
rtl/branch_resolver.sv
rtl/branch_predictor_top.sv
dv/tb_clock_gen.sv
dv/branch_predictor_tb.sv

// File: Makefile
# Verilator simulation of the branch predictor testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = branch_predictor_tb
FILELIST = branch_predictor_top.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: dv/branch_predictor_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "bpred_config.svh"

module branch_predictor_tb
   import bpred_pkg::*;
();

   //////////////////////////////
   // Run length and constants
   //////////////////////////////

   localparam int CLK_PERIOD    = 40;
   localparam int RESET_CYCLES  = 4;
   localparam int SWEEP_CYCLES  = 32;
   localparam int DIRECT_CYCLES = 40;
   localparam int RANDOM_CYCLES = 400;
   localparam int STIM_CYCLES   = RESET_CYCLES + SWEEP_CYCLES + DIRECT_CYCLES + RANDOM_CYCLES;
   localparam int WATCHDOG_NS   = 2 * STIM_CYCLES * CLK_PERIOD;
   localparam int TABLE_SIZE    = 1 << `BPRED_IDX_SIZE;
   localparam int RANDOM_SEED   = 21;

   // Trained branch and a PC sharing its slot under another tag
   localparam word_t PC_A     = 16'h0123;
   localparam word_t TARGET_A = 16'h0456;
   localparam word_t PC_ALIAS = 16'h0a23;

   // DUT connections
   logic  clk;
   logic  reset_n;
   word_t fetch_pc;
   word_t pred_npc;
   logic  resolve_valid;
   word_t resolve_pc;
   logic  resolve_taken;
   word_t resolve_target;
   word_t resolve_pred_npc;
   logic  redirect_valid;
   word_t redirect_pc;
   word_t num_branch;
   word_t num_miss;

   // Reference model state
   btb_entry_t ref_btb [TABLE_SIZE];
   counter_t   ref_bht [TABLE_SIZE];
   word_t      ref_num_branch;
   word_t      ref_num_miss;
   logic       exp_redirect_valid;
   word_t      exp_redirect_pc;

   // Bookkeeping
   string test_name;
   int    check_count;
   int    error_count;
   int    test_count;
   int    test_error_base;

   // Branches in flight with the prediction made at fetch
   word_t fly_pc [$];
   word_t fly_npc [$];

   tb_clock_gen #(
      .PERIOD_NS    (CLK_PERIOD),
      .RESET_CYCLES (RESET_CYCLES)
   ) clock0 (
      .o_clk     (clk),
      .o_reset_n (reset_n)
   );

   branch_predictor_top dut0 (
      .clk                (clk),
      .reset_n            (reset_n),
      .i_fetch_pc         (fetch_pc),
      .o_pred_npc         (pred_npc),
      .i_resolve_valid    (resolve_valid),
      .i_resolve_pc       (resolve_pc),
      .i_resolve_taken    (resolve_taken),
      .i_resolve_target   (resolve_target),
      .i_resolve_pred_npc (resolve_pred_npc),
      .o_redirect_valid   (redirect_valid),
      .o_redirect_pc      (redirect_pc),
      .o_num_branch       (num_branch),
      .o_num_miss         (num_miss)
   );

   //////////////////////////////
   // Reference model
   //////////////////////////////

   // Target only on a tag hit with the counter MSB set
   function automatic word_t pred_npc_ref(input word_t pc);
      btb_entry_t entry;
      counter_t   cnt;
      entry = ref_btb[pc[`BPRED_IDX_SIZE-1:0]];
      cnt   = ref_bht[pc[`BPRED_IDX_SIZE-1:0]];
      if (entry.valid && (entry.tag == pc[`BPRED_WORD_SIZE-1:`BPRED_IDX_SIZE])
          && cnt[`BPRED_CNT_SIZE-1]) begin
         return entry.target;
      end
      return pc + 16'd1;
   endfunction

   // Saturating step toward the outcome
   function automatic counter_t step_counter(input counter_t cnt, input logic taken);
      if (taken) begin
         return (cnt == 2'b11) ? cnt : cnt + 2'b01;
      end
      return (cnt == 2'b00) ? cnt : cnt - 2'b01;
   endfunction

   // Mirrors the DUT state at every edge
   always @(posedge clk) begin : model_update
      idx_t  idx;
      word_t resolved;
      if (!reset_n) begin
         for (int i = 0; i < TABLE_SIZE; i++) begin
            ref_btb[i] = '0;
            ref_bht[i] = `BPRED_CNT_RESET;
         end
         ref_num_branch     = 16'd0;
         ref_num_miss       = 16'd0;
         exp_redirect_valid = 1'b0;
         exp_redirect_pc    = 16'd0;
      end
      else begin
         exp_redirect_valid = 1'b0;
         if (resolve_valid) begin
            idx            = resolve_pc[`BPRED_IDX_SIZE-1:0];
            resolved       = resolve_taken ? resolve_target : resolve_pc + 16'd1;
            ref_num_branch = ref_num_branch + 16'd1;
            // Miss against the carried prediction
            if (resolved != resolve_pred_npc) begin
               exp_redirect_valid = 1'b1;
               exp_redirect_pc    = resolved;
               ref_num_miss       = ref_num_miss + 16'd1;
            end
            ref_bht[idx] = step_counter(ref_bht[idx], resolve_taken);
            if (resolve_taken) begin
               ref_btb[idx].valid  = 1'b1;
               ref_btb[idx].tag    = resolve_pc[`BPRED_WORD_SIZE-1:`BPRED_IDX_SIZE];
               ref_btb[idx].target = resolve_target;
            end
         end
      end
   end

   //////////////////////////////
   // Checking
   //////////////////////////////

   task automatic check_value(input string name, input word_t expected, input word_t actual);
      check_count++;
      if (expected !== actual) begin
         error_count++;
         $display("** Error %s %s: expected %h, actual %h", test_name, name, expected,
                  actual);
      end
   endtask

   // Sampled mid-cycle when outputs have settled
   always @(negedge clk) begin : compare
      if (reset_n) begin
         check_value("pred_npc", pred_npc_ref(fetch_pc), pred_npc);
         check_value("redirect_valid", word_t'(exp_redirect_valid),
                     word_t'(redirect_valid));
         if (exp_redirect_valid) begin
            check_value("redirect_pc", exp_redirect_pc, redirect_pc);
         end
      end
   end

   task automatic start_test(input string name);
      test_name       = name;
      test_error_base = error_count;
   endtask

   task automatic finish_test();
      int errs;
      errs = error_count - test_error_base;
      test_count++;
      $display("Test %s: %s (%0d mismatches)", test_name, (errs == 0) ? "ok" : "bad", errs);
   endtask

   //////////////////////////////
   // Stimulus helpers
   //////////////////////////////

   // Inputs change a little after the edge
   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   // One-cycle strobe that returns just after the sampling edge
   task automatic drive_resolve(input word_t pc, input logic taken, input word_t target,
                                input word_t carried);
      resolve_valid    = 1'b1;
      resolve_pc       = pc;
      resolve_taken    = taken;
      resolve_target   = target;
      resolve_pred_npc = carried;
      next_cycle();
      resolve_valid = 1'b0;
   endtask

   task automatic check_npc_at(input string name, input word_t pc, input word_t expected);
      fetch_pc = pc;
      @(negedge clk);
      check_value(name, expected, pred_npc);
      next_cycle();
   endtask

   task automatic check_redirect(input string name, input logic valid, input word_t pc);
      check_value({name, " valid"}, word_t'(valid), word_t'(redirect_valid));
      if (valid) begin
         check_value({name, " pc"}, pc, redirect_pc);
      end
   endtask

   // Hard limit on run time
   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Watchdog expired, run still busy after %0d ns", WATCHDOG_NS);
      $display("CHECKS FAILED");
      $finish;
   end

   //////////////////////////////
   // Tests
   //////////////////////////////

   initial begin : stimulus
      word_t       pc;
      word_t       target;
      logic        taken;
      void'($urandom(RANDOM_SEED));
      fetch_pc         = 16'd0;
      resolve_valid    = 1'b0;
      resolve_pc       = 16'd0;
      resolve_taken    = 1'b0;
      resolve_target   = 16'd0;
      resolve_pred_npc = 16'd0;
      check_count      = 0;
      error_count      = 0;
      test_count       = 0;
      test_name        = "reset";
      @(posedge reset_n);

      // Empty tables fall through everywhere
      start_test("reset_state");
      check_value("reset num_branch", 16'd0, num_branch);
      check_value("reset num_miss", 16'd0, num_miss);
      check_value("reset redirect", 16'd0, word_t'(redirect_valid));
      for (int i = 0; i < SWEEP_CYCLES; i++) begin
         pc = word_t'($urandom);
         check_npc_at("reset sweep", pc, pc + 16'd1);
      end
      finish_test();

      // Counter 01 to 10 and BTB entry now valid
      start_test("taken_redirect");
      drive_resolve(PC_A, 1'b1, TARGET_A, PC_A + 16'd1);
      check_redirect("taken redirect", 1'b1, TARGET_A);
      next_cycle();
      check_redirect("taken pulse end", 1'b0, 16'd0);
      check_npc_at("taken predict", PC_A, TARGET_A);
      check_value("taken num_branch", 16'd1, num_branch);
      check_value("taken num_miss", 16'd1, num_miss);
      finish_test();

      start_test("hysteresis");
      // 10 to 11 with a correct prediction
      drive_resolve(PC_A, 1'b1, TARGET_A, TARGET_A);
      check_redirect("hyst train", 1'b0, 16'd0);
      // 11 to 10 still above the threshold
      drive_resolve(PC_A, 1'b0, TARGET_A, TARGET_A);
      check_redirect("hyst first untaken", 1'b1, PC_A + 16'd1);
      check_npc_at("hyst still taken", PC_A, TARGET_A);
      // 10 to 01 where the carried prediction matched
      drive_resolve(PC_A, 1'b0, TARGET_A, PC_A + 16'd1);
      check_redirect("hyst second untaken", 1'b0, 16'd0);
      check_npc_at("hyst now untaken", PC_A, PC_A + 16'd1);
      finish_test();

      // Retrain then probe another tag in the same slot
      start_test("aliasing");
      drive_resolve(PC_A, 1'b1, TARGET_A, PC_A + 16'd1);
      check_redirect("alias retrain", 1'b1, TARGET_A);
      check_npc_at("alias other tag", PC_ALIAS, PC_ALIAS + 16'd1);
      check_npc_at("alias trained", PC_A, TARGET_A);
      finish_test();

      start_test("random_stream");
      for (int i = 0; i < RANDOM_CYCLES; i++) begin
         // Four tags over all sixteen slots
         pc       = 16'h4000 | (word_t'($urandom) & 16'h003f);
         fetch_pc = pc;
         if ($urandom_range(0, 1) == 1) begin
            fly_pc.push_back(pc);
            fly_npc.push_back(pred_npc_ref(pc));
         end
         resolve_valid = 1'b0;
         // Oldest branch in flight resolves often back to back
         if ((fly_pc.size() > 0) && ($urandom_range(0, 1) == 1)) begin
            pc     = fly_pc.pop_front();
            taken  = ($urandom_range(0, 9) < 7);
            target = ($urandom_range(0, 7) == 0) ? word_t'($urandom) : pc ^ 16'h0ff0;
            resolve_valid    = 1'b1;
            resolve_pc       = pc;
            resolve_taken    = taken;
            resolve_target   = target;
            resolve_pred_npc = fly_npc.pop_front();
         end
         next_cycle();
      end
      resolve_valid = 1'b0;
      next_cycle();
      next_cycle();
      check_value("random num_branch", ref_num_branch, num_branch);
      check_value("random num_miss", ref_num_miss, num_miss);
      finish_test();

      $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
               error_count);
      if (error_count == 0) begin
         $display("ALL CHECKS PASSED");
      end
      else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

// Free running clock plus a reset held low for a fixed number of cycles
module tb_clock_gen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 4
) (
   output logic o_clk,
   output logic o_reset_n
);

   // Half period toggle
   initial begin
      o_clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2);
         o_clk = ~o_clk;
      end
   end

   // Release lines up with the stimulus offset after an edge
   initial begin
      o_reset_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge o_clk);
      #2;
      o_reset_n = 1'b1;
   end

endmodule

`default_nettype wire

// File: rtl/branch_predictor_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "bpred_config.svh"

// Standalone predictor: BTB and BHT side by side, resolver on top
module branch_predictor_top
   import bpred_pkg::*;
(
   input  wire        clk,
   input  wire        reset_n,

   // Fetch lookup
   input  wire word_t i_fetch_pc,
   output word_t      o_pred_npc,

   // Resolved branch strobe
   input  wire        i_resolve_valid,
   input  wire word_t i_resolve_pc,
   input  wire        i_resolve_taken,
   input  wire word_t i_resolve_target,
   input  wire word_t i_resolve_pred_npc,

   // Redirect and statistics
   output logic       o_redirect_valid,
   output word_t      o_redirect_pc,
   output word_t      o_num_branch,
   output word_t      o_num_miss
);

   localparam btb_entry_t BTB_INVALID = '{valid: 1'b0, tag: '0, target: '0};

   // Table indices from the low PC bits
   idx_t       fetch_idx;
   idx_t       resolve_idx;

   // Lookup results
   btb_entry_t btb_lookup;
   counter_t   bht_lookup;
   counter_t   bht_current;

   // Update path
   logic       btb_write;
   btb_entry_t btb_entry;
   logic       bht_write;
   counter_t   bht_entry;

   assign fetch_idx   = i_fetch_pc[`BPRED_IDX_SIZE-1:0];
   assign resolve_idx = i_resolve_pc[`BPRED_IDX_SIZE-1:0];

   //////////////////////////////
   // Tables
   //////////////////////////////

   // BTB update read port not needed, entry rewritten whole
   predictor_table #(
      .ENTRY_T     (btb_entry_t),
      .RESET_VALUE (BTB_INVALID)
   ) btb0 (
      .clk            (clk),
      .reset_n        (reset_n),
      .i_lookup_idx   (fetch_idx),
      .o_lookup_entry (btb_lookup),
      .i_update_idx   (resolve_idx),
      .o_update_entry (),
      .i_write        (btb_write),
      .i_write_entry  (btb_entry)
   );

   // BHT update read feeds the saturating step
   predictor_table #(
      .ENTRY_T     (counter_t),
      .RESET_VALUE (`BPRED_CNT_RESET)
   ) bht0 (
      .clk            (clk),
      .reset_n        (reset_n),
      .i_lookup_idx   (fetch_idx),
      .o_lookup_entry (bht_lookup),
      .i_update_idx   (resolve_idx),
      .o_update_entry (bht_current),
      .i_write        (bht_write),
      .i_write_entry  (bht_entry)
   );

   //////////////////////////////
   // Combining unit
   //////////////////////////////

   branch_resolver resolver0 (
      .clk                (clk),
      .reset_n            (reset_n),
      .i_fetch_pc         (i_fetch_pc),
      .i_btb_lookup       (btb_lookup),
      .i_bht_lookup       (bht_lookup),
      .o_pred_npc         (o_pred_npc),
      .i_resolve_valid    (i_resolve_valid),
      .i_resolve_pc       (i_resolve_pc),
      .i_resolve_taken    (i_resolve_taken),
      .i_resolve_target   (i_resolve_target),
      .i_resolve_pred_npc (i_resolve_pred_npc),
      .i_bht_current      (bht_current),
      .o_btb_write        (btb_write),
      .o_btb_entry        (btb_entry),
      .o_bht_write        (bht_write),
      .o_bht_entry        (bht_entry),
      .o_redirect_valid   (o_redirect_valid),
      .o_redirect_pc      (o_redirect_pc),
      .o_num_branch       (o_num_branch),
      .o_num_miss         (o_num_miss)
   );

endmodule

`default_nettype wire

// File: rtl/branch_resolver.sv
`timescale 1ns/1ns
`default_nettype none

`include "bpred_config.svh"

// Combines BTB and BHT lookups into the next PC prediction
// Turns resolve strobes into table writes, redirects and statistics
module branch_resolver
   import bpred_pkg::*;
(
   input  wire             clk,
   input  wire             reset_n,

   // Fetch lookup
   input  wire word_t      i_fetch_pc,
   input  wire btb_entry_t i_btb_lookup,
   input  wire counter_t   i_bht_lookup,
   output word_t           o_pred_npc,

   // Resolved branch from the pipeline
   input  wire             i_resolve_valid,
   input  wire word_t      i_resolve_pc,
   input  wire             i_resolve_taken,
   input  wire word_t      i_resolve_target,
   input  wire word_t      i_resolve_pred_npc,

   // Current BHT state at the resolved index
   input  wire counter_t   i_bht_current,

   // Table updates
   output logic            o_btb_write,
   output btb_entry_t      o_btb_entry,
   output logic            o_bht_write,
   output counter_t        o_bht_entry,

   // Misprediction redirect, one cycle after the strobe
   output logic            o_redirect_valid,
   output word_t           o_redirect_pc,

   // Statistics
   output word_t           o_num_branch,
   output word_t           o_num_miss
);

   // Fetch side
   tag_t     fetch_tag;
   logic     btb_hit;
   logic     pred_taken;
   word_t    fetch_seq_pc;

   // Resolve side
   word_t    resolve_seq_pc;
   word_t    resolved_pc;
   logic     resolve_miss;
   counter_t bht_next;

   //////////////////////////////
   // Prediction
   //////////////////////////////

   assign fetch_tag    = i_fetch_pc[`BPRED_WORD_SIZE-1:`BPRED_IDX_SIZE];
   assign fetch_seq_pc = i_fetch_pc + word_t'(1);

   // Hit needs a valid entry owned by this PC
   assign btb_hit    = i_btb_lookup.valid && (i_btb_lookup.tag == fetch_tag);
   assign pred_taken = i_bht_lookup[`BPRED_CNT_SIZE-1];

   // Target only when both tables agree, else fall through
   assign o_pred_npc = (btb_hit && pred_taken) ? i_btb_lookup.target : fetch_seq_pc;

   //////////////////////////////
   // Resolution
   //////////////////////////////

   assign resolve_seq_pc = i_resolve_pc + word_t'(1);
   assign resolved_pc    = i_resolve_taken ? i_resolve_target : resolve_seq_pc;

   // Compare against the prediction carried down the pipe
   assign resolve_miss = i_resolve_valid && (resolved_pc != i_resolve_pred_npc);

   // One step toward the outcome, saturating at both ends
   always_comb begin
      bht_next = i_bht_current;
      if (i_resolve_taken) begin
         if (i_bht_current != '1) begin
            bht_next = i_bht_current + counter_t'(1);
         end
      end
      else if (i_bht_current != '0) begin
         bht_next = i_bht_current - counter_t'(1);
      end
   end

   // BHT updated on every resolved branch
   assign o_bht_write = i_resolve_valid;
   assign o_bht_entry = bht_next;

   // BTB only learns taken branches
   assign o_btb_write        = i_resolve_valid && i_resolve_taken;
   assign o_btb_entry.valid  = 1'b1;
   assign o_btb_entry.tag    = i_resolve_pc[`BPRED_WORD_SIZE-1:`BPRED_IDX_SIZE];
   assign o_btb_entry.target = i_resolve_target;

   //////////////////////////////
   // Redirect and statistics
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         o_redirect_valid <= 1'b0;
         o_num_branch     <= '0;
         o_num_miss       <= '0;
      end
      else begin
         // Pulse lasts one cycle per missed strobe
         o_redirect_valid <= resolve_miss;
         if (i_resolve_valid) begin
            o_num_branch <= o_num_branch + word_t'(1);
         end
         if (resolve_miss) begin
            o_num_miss <= o_num_miss + word_t'(1);
         end
      end
   end

   // Redirect PC only meaningful with o_redirect_valid
   always_ff @(posedge clk) begin
      if (resolve_miss) begin
         o_redirect_pc <= resolved_pc;
      end
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   // Back-to-back redirects need back-to-back strobes
   a_redirect_pulse: assert property (
      @(posedge clk) disable iff (!reset_n)
      (o_redirect_valid && $past(o_redirect_valid))
         |-> ($past(i_resolve_valid) && $past(i_resolve_valid, 2))
   );

   // Statistics only move upward outside reset
   a_counts_monotonic: assert property (
      @(posedge clk) disable iff (!reset_n)
      $past(reset_n) |-> ((o_num_branch >= $past(o_num_branch))
                          && (o_num_miss >= $past(o_num_miss)))
   );

endmodule

`default_nettype wire

// File: rtl/predictor_table.sv
`timescale 1ns/1ns
`default_nettype none

`include "bpred_config.svh"

// Direct-mapped table shared by BTB and BHT
// Lookup port serves fetch, update port serves resolution
module predictor_table
   import bpred_pkg::*;
#(
   parameter type    ENTRY_T     = counter_t,
   parameter ENTRY_T RESET_VALUE = ENTRY_T'(0)
) (
   input  wire         clk,
   input  wire         reset_n,

   // Fetch side read
   input  wire idx_t   i_lookup_idx,
   output ENTRY_T      o_lookup_entry,

   // Resolution side read
   input  wire idx_t   i_update_idx,
   output ENTRY_T      o_update_entry,

   // Resolution side write, same index as update read
   input  wire         i_write,
   input  wire ENTRY_T i_write_entry
);

   //////////////////////////////
   // Storage
   //////////////////////////////

   localparam int NUM_ENTRIES = 1 << `BPRED_IDX_SIZE;

   ENTRY_T table_mem [NUM_ENTRIES];

   //////////////////////////////
   // Read ports
   //////////////////////////////

   // Combinational reads
   // A same-cycle write is not yet visible here
   assign o_lookup_entry = table_mem[i_lookup_idx];
   assign o_update_entry = table_mem[i_update_idx];

   //////////////////////////////
   // Write port
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         // Whole table back to its known state
         for (int i = 0; i < NUM_ENTRIES; i++) begin
            table_mem[i] <= RESET_VALUE;
         end
      end
      else if (i_write) begin
         table_mem[i_update_idx] <= i_write_entry;
      end
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   // Write address must be known when a write is requested
   a_write_idx_known: assert property (
      @(posedge clk) disable iff (!reset_n)
      i_write |-> !$isunknown(i_update_idx)
   );

endmodule

`default_nettype wire

// File: rtl/bpred_pkg.sv
`default_nettype none

`include "bpred_config.svh"

package bpred_pkg;

   //////////////////////////////
   // Address types
   //////////////////////////////

   // Full instruction address
   typedef logic [`BPRED_WORD_SIZE-1:0] word_t;

   // Low PC bits select a table entry
   typedef logic [`BPRED_IDX_SIZE-1:0] idx_t;

   // Remaining high PC bits
   typedef logic [`BPRED_WORD_SIZE-`BPRED_IDX_SIZE-1:0] tag_t;

   //////////////////////////////
   // Table payloads
   //////////////////////////////

   // Saturating history counter, MSB set means predict taken
   typedef logic [`BPRED_CNT_SIZE-1:0] counter_t;

   // BTB record
   typedef struct packed {
      logic  valid;
      tag_t  tag;
      word_t target;
   } btb_entry_t;

endpackage

`default_nettype wire

// File: rtl/bpred_config.svh
`ifndef BPRED_CONFIG_SVH
`define BPRED_CONFIG_SVH

//////////////////////////////
// Predictor sizing
//////////////////////////////

// Instruction address width
`define BPRED_WORD_SIZE 16

// Table index width, 16 entries per table
`define BPRED_IDX_SIZE 4

// History counter width and its post-reset value (weakly not-taken)
`define BPRED_CNT_SIZE 2
`define BPRED_CNT_RESET 2'b01

`endif
